//--- logic/fb_pkg.sv
package fb_pkg;

  // Default frame size in pixels.
  parameter int DISPLAY_WIDTH_DEF  = 16;
  parameter int DISPLAY_HEIGHT_DEF = 12;

  // One pixel word.
  parameter int PIXEL_BITS = 16;
  typedef logic [PIXEL_BITS-1:0] pixel_t;

  // One screen coordinate, x or y.
  parameter int COORD_BITS = 8;
  typedef logic [COORD_BITS-1:0] coord_t;

  // Linear frame address, y * width + x.
  // Eight bits cover the 192 pixels of the default frame.
  parameter int ADDR_BITS = 8;
  typedef logic [ADDR_BITS-1:0] fb_addr_t;

  // Cycles from read address to read data in a frame RAM.
  parameter int RAM_LATENCY = 2;

endpackage

//--- logic/wb_regs_pkg.sv
package wb_regs_pkg;

  // Bus widths.
  parameter int WB_DATA_BITS = 32;
  typedef logic [WB_DATA_BITS-1:0] wb_data_t;

  parameter int WB_ADR_BITS = 3;
  typedef logic [WB_ADR_BITS-1:0] wb_adr_t;

  // Word addresses.
  parameter wb_adr_t REG_CTRL   = 3'd0; // Start, swap, auto swap.
  parameter wb_adr_t REG_STATUS = 3'd1; // Read only.
  parameter wb_adr_t REG_RECT_X = 3'd2; // x0 low byte, x1 next byte.
  parameter wb_adr_t REG_RECT_Y = 3'd3; // y0 low byte, y1 next byte.
  parameter wb_adr_t REG_COLOR  = 3'd4;

  // CTRL bits.
  parameter int CTRL_START = 0;
  parameter int CTRL_SWAP  = 1;
  parameter int CTRL_AUTO  = 2;

  // STATUS bits.
  parameter int STAT_BUSY  = 0;
  parameter int STAT_PEND  = 1;
  parameter int STAT_FRONT = 2;

endpackage

//--- logic/frame_ram.sv
`timescale 1ns/100ps

module frame_ram #(
  parameter int ram_depth = 192,
  parameter int ram_width = 16
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wr_en,
  input  fb_pkg::fb_addr_t     wr_addr,
  input  logic [ram_width-1:0] wr_data,
  input  fb_pkg::fb_addr_t     rd_addr,
  output logic [ram_width-1:0] rd_data
);

  logic [ram_width-1:0] mem [ram_depth];
  logic [ram_width-1:0] rd_stage; // First output stage.

  // Contents start cleared in simulation.
  initial begin
    for (int i = 0; i < ram_depth; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read first, then one more register stage.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_stage <= '0;
      rd_data  <= '0;
    end else begin
      rd_stage <= mem[rd_addr];
      rd_data  <= rd_stage;
    end
  end

endmodule

//--- logic/frame_buffer_pair.sv
`timescale 1ns/100ps

module frame_buffer_pair #(
  parameter int depth = fb_pkg::DISPLAY_WIDTH_DEF * fb_pkg::DISPLAY_HEIGHT_DEF
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             swap_pending,
  input  logic             frame_first,
  input  logic             wr_en,
  input  fb_pkg::fb_addr_t wr_addr,
  input  fb_pkg::pixel_t   wr_data,
  input  fb_pkg::fb_addr_t rd_addr,
  output fb_pkg::pixel_t   rd_data,
  output logic             swap_ack,
  output logic             front_index
);
  import fb_pkg::*;

  logic                   front_sel; // Index of the front buffer.
  logic                   sel_now;   // Front select including this cycle's swap.
  logic [RAM_LATENCY-1:0] sel_pipe;
  pixel_t                 ram0_rd_data;
  pixel_t                 ram1_rd_data;

  // Swap only when the scan restarts at pixel (0,0).
  assign swap_ack = frame_first && swap_pending;
  assign sel_now  = front_sel ^ swap_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      front_sel <= 1'b0;
      sel_pipe  <= '0;
    end else begin
      front_sel <= sel_now;
      sel_pipe  <= {sel_pipe[RAM_LATENCY-2:0], sel_now}; // Follows the RAM read delay.
    end
  end

  // Data comes from the buffer that was front when its address went out.
  assign front_index = sel_pipe[RAM_LATENCY-1];
  assign rd_data     = front_index ? ram1_rd_data : ram0_rd_data;

  // Writes land in whichever buffer is back.
  frame_ram #(
    .ram_depth(depth),
    .ram_width(PIXEL_BITS)
  ) u_ram0 (
    .clk    (clk),
    .rst    (rst),
    .wr_en  (wr_en && sel_now),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd_addr(rd_addr),
    .rd_data(ram0_rd_data)
  );

  frame_ram #(
    .ram_depth(depth),
    .ram_width(PIXEL_BITS)
  ) u_ram1 (
    .clk    (clk),
    .rst    (rst),
    .wr_en  (wr_en && !sel_now),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd_addr(rd_addr),
    .rd_data(ram1_rd_data)
  );

endmodule

//--- logic/rect_fill_engine.sv
`timescale 1ns/100ps

module rect_fill_engine #(
  parameter int display_width  = fb_pkg::DISPLAY_WIDTH_DEF,
  parameter int display_height = fb_pkg::DISPLAY_HEIGHT_DEF
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             fill_start,
  input  fb_pkg::coord_t   x0,
  input  fb_pkg::coord_t   x1,
  input  fb_pkg::coord_t   y0,
  input  fb_pkg::coord_t   y1,
  input  fb_pkg::pixel_t   color,
  output logic             fill_busy,
  output logic             fill_done,
  output logic             fill_we,
  output fb_pkg::fb_addr_t fill_addr,
  output fb_pkg::pixel_t   fill_data
);
  import fb_pkg::*;

  localparam coord_t   x_max    = coord_t'(display_width - 1);
  localparam coord_t   y_max    = coord_t'(display_height - 1);
  localparam fb_addr_t row_step = fb_addr_t'(display_width);

  coord_t   x_lo;      // Left edge, row restart value.
  coord_t   x_hi;      // Clamped right edge.
  coord_t   y_hi;      // Clamped bottom edge.
  coord_t   x_q;
  coord_t   y_q;
  fb_addr_t row_base;  // Address of (0, y_q).
  pixel_t   color_q;
  logic     accept;
  logic     empty;
  logic     last;

  assign accept = fill_start && !fill_busy; // Starts while busy are ignored.

  // y_q never passes y_hi once walking, so this only fires on the first cycle.
  assign empty = (x_lo > x_hi) || (y_q > y_hi);
  assign last  = (x_q == x_hi) && (y_q == y_hi);

  assign fill_we   = fill_busy && !empty;
  assign fill_done = fill_busy && (empty || last);
  assign fill_addr = row_base + x_q;
  assign fill_data = color_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      fill_busy <= 1'b0;
    end else if (accept) begin
      fill_busy <= 1'b1;
    end else if (fill_done) begin
      fill_busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      x_lo     <= x0;
      x_hi     <= (x1 > x_max) ? x_max : x1;
      y_hi     <= (y1 > y_max) ? y_max : y1;
      x_q      <= x0;
      y_q      <= y0;
      row_base <= fb_addr_t'(y0 * display_width); // Constant factor.
      color_q  <= color;
    end else if (fill_we && !last) begin
      if (x_q == x_hi) begin
        x_q      <= x_lo; // Next row.
        y_q      <= y_q + 1'b1;
        row_base <= row_base + row_step;
      end else begin
        x_q <= x_q + 1'b1;
      end
    end
  end

endmodule

//--- logic/fb_ctrl_regs.sv
`timescale 1ns/100ps

module fb_ctrl_regs (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  wb_regs_pkg::wb_adr_t  wb_adr,
  input  wb_regs_pkg::wb_data_t wb_dat_w,
  output wb_regs_pkg::wb_data_t wb_dat_r,
  output logic                  wb_ack,
  input  logic                  fill_busy,
  input  logic                  fill_done,
  input  logic                  swap_ack,
  input  logic                  front_index,
  output logic                  fill_start,
  output fb_pkg::coord_t        x0,
  output fb_pkg::coord_t        x1,
  output fb_pkg::coord_t        y0,
  output fb_pkg::coord_t        y1,
  output fb_pkg::pixel_t        color,
  output logic                  swap_pending
);
  import fb_pkg::*;
  import wb_regs_pkg::*;

  logic     access;    // Request not yet acked.
  logic     wr;
  logic     ctrl_wr;
  logic     auto_swap;
  wb_data_t rd_mux;

  assign access  = wb_cyc && wb_stb && !wb_ack;
  assign wr      = access && wb_we;
  assign ctrl_wr = wr && (wb_adr == REG_CTRL);

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= access; // One wait cycle, one ack cycle.
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      auto_swap <= 1'b0;
      x0        <= '0;
      x1        <= '0;
      y0        <= '0;
      y1        <= '0;
      color     <= '0;
    end else if (wr) begin
      case (wb_adr)
        REG_CTRL:   auto_swap <= wb_dat_w[CTRL_AUTO];
        REG_RECT_X: {x1, x0} <= wb_dat_w[2*COORD_BITS-1:0];
        REG_RECT_Y: {y1, y0} <= wb_dat_w[2*COORD_BITS-1:0];
        REG_COLOR:  color <= wb_dat_w[PIXEL_BITS-1:0];
        default: ;
      endcase
    end
  end

  // Start pulse and pending swap.
  always_ff @(posedge clk) begin
    if (rst) begin
      fill_start   <= 1'b0;
      swap_pending <= 1'b0;
    end else begin
      // A fill finishing this cycle frees the engine in time.
      fill_start   <= ctrl_wr && wb_dat_w[CTRL_START] && (!fill_busy || fill_done);
      swap_pending <= (swap_pending && !swap_ack)
                    || (ctrl_wr && wb_dat_w[CTRL_SWAP])
                    || (fill_done && auto_swap);
    end
  end

  always_comb begin
    rd_mux = '0;
    case (wb_adr)
      REG_CTRL: rd_mux[CTRL_AUTO] = auto_swap;
      REG_STATUS: begin
        rd_mux[STAT_BUSY]  = fill_busy;
        rd_mux[STAT_PEND]  = swap_pending;
        rd_mux[STAT_FRONT] = front_index;
      end
      REG_RECT_X: rd_mux[2*COORD_BITS-1:0] = {x1, x0};
      REG_RECT_Y: rd_mux[2*COORD_BITS-1:0] = {y1, y0};
      REG_COLOR:  rd_mux[PIXEL_BITS-1:0] = color;
      default: ; // Unmapped words read zero.
    endcase
  end

  always_ff @(posedge clk) begin
    if (access && !wb_we) begin
      wb_dat_r <= rd_mux; // Held through the ack cycle.
    end
  end

endmodule

//--- logic/scan_reader.sv
`timescale 1ns/100ps

module scan_reader #(
  parameter int display_width  = fb_pkg::DISPLAY_WIDTH_DEF,
  parameter int display_height = fb_pkg::DISPLAY_HEIGHT_DEF
) (
  input  logic             clk,
  input  logic             rst,
  output fb_pkg::fb_addr_t scan_addr,
  output logic             frame_first,
  output logic             pixel_valid,
  output logic             pixel_first
);
  import fb_pkg::*;

  localparam fb_addr_t last_addr = fb_addr_t'(display_width * display_height - 1);

  logic [RAM_LATENCY-1:0] valid_pipe;
  logic [RAM_LATENCY-1:0] first_pipe;

  // Pixel (0,0) opens each frame.
  assign frame_first = (scan_addr == '0);

  // Raster counter, no stall.
  always_ff @(posedge clk) begin
    if (rst) begin
      scan_addr <= '0;
    end else if (scan_addr == last_addr) begin
      scan_addr <= '0;
    end else begin
      scan_addr <= scan_addr + 1'b1;
    end
  end

  // Markers travel alongside the RAM read.
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_pipe <= '0;
      first_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[RAM_LATENCY-2:0], 1'b1};
      first_pipe <= {first_pipe[RAM_LATENCY-2:0], frame_first};
    end
  end

  assign pixel_valid = valid_pipe[RAM_LATENCY-1];
  assign pixel_first = first_pipe[RAM_LATENCY-1];

endmodule

//--- logic/fb_subsystem_top.sv
`timescale 1ns/100ps

module fb_subsystem_top #(
  parameter int display_width  = fb_pkg::DISPLAY_WIDTH_DEF,
  parameter int display_height = fb_pkg::DISPLAY_HEIGHT_DEF
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  wb_regs_pkg::wb_adr_t  wb_adr,
  input  wb_regs_pkg::wb_data_t wb_dat_w,
  output wb_regs_pkg::wb_data_t wb_dat_r,
  output logic                  wb_ack,
  output fb_pkg::pixel_t        pixel_data,
  output logic                  pixel_valid,
  output logic                  pixel_first
);
  import fb_pkg::*;

  localparam int depth = display_width * display_height;

  logic     fill_start;
  logic     fill_busy;
  logic     fill_done;
  logic     fill_we;
  fb_addr_t fill_addr;
  pixel_t   fill_data;
  coord_t   x0;
  coord_t   x1;
  coord_t   y0;
  coord_t   y1;
  pixel_t   color;
  logic     swap_pending;
  logic     swap_ack;
  logic     front_index;
  fb_addr_t scan_addr;
  logic     frame_first;

  fb_ctrl_regs u_regs (
    .clk         (clk),
    .rst         (rst),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .fill_busy   (fill_busy),
    .fill_done   (fill_done),
    .swap_ack    (swap_ack),
    .front_index (front_index),
    .fill_start  (fill_start),
    .x0          (x0),
    .x1          (x1),
    .y0          (y0),
    .y1          (y1),
    .color       (color),
    .swap_pending(swap_pending)
  );

  rect_fill_engine #(
    .display_width (display_width),
    .display_height(display_height)
  ) u_fill (
    .clk       (clk),
    .rst       (rst),
    .fill_start(fill_start),
    .x0        (x0),
    .x1        (x1),
    .y0        (y0),
    .y1        (y1),
    .color     (color),
    .fill_busy (fill_busy),
    .fill_done (fill_done),
    .fill_we   (fill_we),
    .fill_addr (fill_addr),
    .fill_data (fill_data)
  );

  frame_buffer_pair #(
    .depth(depth)
  ) u_buffers (
    .clk         (clk),
    .rst         (rst),
    .swap_pending(swap_pending),
    .frame_first (frame_first),
    .wr_en       (fill_we),
    .wr_addr     (fill_addr),
    .wr_data     (fill_data),
    .rd_addr     (scan_addr),
    .rd_data     (pixel_data),
    .swap_ack    (swap_ack),
    .front_index (front_index)
  );

  scan_reader #(
    .display_width (display_width),
    .display_height(display_height)
  ) u_scan (
    .clk        (clk),
    .rst        (rst),
    .scan_addr  (scan_addr),
    .frame_first(frame_first),
    .pixel_valid(pixel_valid),
    .pixel_first(pixel_first)
  );

endmodule

//--- tests/fb_subsystem_props.sv
`timescale 1ns/100ps

module fb_subsystem_props (
  input logic clk,
  input logic rst,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic fill_start,
  input logic fill_busy
);

  int failures = 0; // Summed into the end of run report.

  ack_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
    else begin
      failures++;
      $error("wb_ack stayed high for more than one cycle");
    end

  // Ack only inside a cycle.
  ack_in_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |-> wb_cyc && wb_stb)
    else begin
      failures++;
      $error("wb_ack high without cyc and stb");
    end

  start_when_idle: assert property (@(posedge clk) disable iff (rst) fill_start |-> !fill_busy)
    else begin
      failures++;
      $error("fill_start issued while the engine was busy");
    end

endmodule

bind fb_ctrl_regs fb_subsystem_props u_props (
  .clk       (clk),
  .rst       (rst),
  .wb_cyc    (wb_cyc),
  .wb_stb    (wb_stb),
  .wb_ack    (wb_ack),
  .fill_start(fill_start),
  .fill_busy (fill_busy)
);

//--- tests/fb_subsystem_tb.sv
`timescale 1ns/100ps

module fb_subsystem_tb;
  import fb_pkg::*;
  import wb_regs_pkg::*;

  localparam int disp_w     = DISPLAY_WIDTH_DEF;
  localparam int disp_h     = DISPLAY_HEIGHT_DEF;
  localparam int frame_px   = disp_w * disp_h;
  localparam int auto_fills = 6;
  // Each swap may cost up to four frames, plus the plain frame waits.
  localparam int frame_waits    = 3 + 4 * (auto_fills + 3);
  localparam int timeout_cycles = (1 + auto_fills + frame_waits) * frame_px + 2000;

  logic     clk = 1'b0;
  logic     rst;
  logic     wb_cyc;
  logic     wb_stb;
  logic     wb_we;
  wb_adr_t  wb_adr;
  wb_data_t wb_dat_w;
  wb_data_t wb_dat_r;
  logic     wb_ack;
  pixel_t   pixel_data;
  logic     pixel_valid;
  logic     pixel_first;

  pixel_t model_mem [2][frame_px]; // Reference frames, indexed by buffer.
  int     model_front = 0;
  logic   pend_seen = 1'b0;
  logic   swap_due = 1'b0;
  logic   scanning = 1'b0;
  int     pix_idx = 0;
  int     frames_done = 0;
  int     cycles_after_rst = 0;
  string  test_name = "none";
  int     errors = 0;
  int     checks = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     errors_at_start = 0;
  logic   auto_on = 1'b0;
  int     exp_front = 0;

  always #10 clk = ~clk;

  fb_subsystem_top DUT (
    .clk        (clk),
    .rst        (rst),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .pixel_data (pixel_data),
    .pixel_valid(pixel_valid),
    .pixel_first(pixel_first)
  );

  task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Error: %s %s expected %h actual %h", test_name, what, expected, actual);
    end
  endtask

  // Classic cycle, held until ack.
  task automatic wb_write(wb_adr_t adr, wb_data_t data);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_dat_w <= data;
    do @(posedge clk); while (!wb_ack);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_read(wb_adr_t adr, output wb_data_t data);
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    do @(posedge clk); while (!wb_ack);
    data = wb_dat_r; // Valid during the ack cycle.
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  // Same clamping as the display edge, into the model back frame.
  // Returns the number of pixels written.
  function automatic int apply_fill(int xa, int xb, int ya, int yb, pixel_t c);
    int back;
    int n;
    back = 1 - model_front;
    n    = 0;
    if (xb > disp_w - 1) xb = disp_w - 1;
    if (yb > disp_h - 1) yb = disp_h - 1;
    for (int y = ya; y <= yb; y++) begin
      for (int x = xa; x <= xb; x++) begin
        model_mem[back][y * disp_w + x] = c;
        n++;
      end
    end
    return n;
  endfunction

  function automatic wb_data_t ctrl_word(logic start, logic swap);
    wb_data_t w;
    w             = '0;
    w[CTRL_START] = start;
    w[CTRL_SWAP]  = swap;
    w[CTRL_AUTO]  = auto_on;
    return w;
  endfunction

  // Compare every valid pixel with the model front frame.
  always @(posedge clk) begin
    if (rst) begin
      pend_seen        = 1'b0;
      swap_due         = 1'b0;
      cycles_after_rst = 0;
    end else begin
      // Valid rises two cycles after reset.
      check_value("pixel valid", cycles_after_rst >= 2, pixel_valid);
      cycles_after_rst++;
      if (pend_seen && !DUT.swap_pending) swap_due = 1'b1;
      pend_seen = DUT.swap_pending;
      if (pixel_valid) begin
        if (pixel_first) begin
          if (swap_due) model_front = 1 - model_front; // New front from pixel (0,0).
          swap_due = 1'b0;
          if (scanning) check_value("frame length", frame_px, pix_idx);
          scanning = 1'b1;
          pix_idx  = 0;
        end
        if (scanning && pix_idx < frame_px) begin
          check_value($sformatf("pixel %0d", pix_idx), model_mem[model_front][pix_idx],
                      pixel_data);
          pix_idx++;
          if (pix_idx == frame_px) frames_done++;
        end
      end
    end
  end

  task automatic wait_frames(int n);
    int target;
    target = frames_done + n;
    wait (frames_done >= target);
  endtask

  task automatic wait_frame_start();
    do @(posedge clk); while (!pixel_first);
  endtask

  task automatic run_fill(int xa, int xb, int ya, int yb, pixel_t c, logic restart);
    wb_data_t st;
    int       area;
    wb_write(REG_RECT_X, {16'h0, 8'(xb), 8'(xa)});
    wb_write(REG_RECT_Y, {16'h0, 8'(yb), 8'(ya)});
    wb_write(REG_COLOR, {16'h0, c});
    area = apply_fill(xa, xb, ya, yb, c);
    wb_write(REG_CTRL, ctrl_word(1'b1, 1'b0));
    wb_read(REG_STATUS, st);
    // Long enough to still be running at the status read.
    if (area >= 4) check_value("busy set", 1, st[STAT_BUSY]);
    if (restart) wb_write(REG_CTRL, ctrl_word(1'b1, 1'b0)); // Dropped while busy.
    do wb_read(REG_STATUS, st); while (st[STAT_BUSY]);
  endtask

  // Pending clears, then the next frame must come from the other buffer.
  task automatic wait_swap();
    wb_data_t st;
    do wb_read(REG_STATUS, st); while (st[STAT_PEND]);
    wait_frame_start();
    wb_read(REG_STATUS, st);
    check_value("front index", exp_front, st[STAT_FRONT]);
    wait_frames(1);
  endtask

  task automatic request_swap();
    wb_data_t st;
    wait_frame_start(); // Far from the next swap point.
    wb_write(REG_CTRL, ctrl_word(1'b0, 1'b1));
    wb_read(REG_STATUS, st);
    check_value("swap pending", 1, st[STAT_PEND]);
    exp_front = 1 - exp_front;
    wait_swap();
  endtask

  task automatic start_test(string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    int n;
    n = errors - errors_at_start;
    tests_run++;
    if (n != 0) tests_failed++;
    $display("Test %0d %s: %0d errors", tests_run, test_name, n);
  endtask

  initial begin
    repeat (timeout_cycles) @(posedge clk);
    $display("Run timed out after %0d cycles, a bus access or frame never finished",
             timeout_cycles);
    $display("Regression failed");
    $finish;
  end

  initial begin
    wb_data_t rd;
    int       seed;
    int       xa;
    int       ya;
    int       orig_front;
    rst      = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    foreach (model_mem[b, a]) model_mem[b][a] = '0;
    seed = $urandom(32'h7b3d_546d);
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    start_test("reset state");
    wb_read(REG_STATUS, rd);
    check_value("status", 0, rd);
    wait_frames(1);
    end_test();

    start_test("register readback");
    wb_write(REG_RECT_X, 32'hffff_1234);
    wb_read(REG_RECT_X, rd);
    check_value("rect x", 32'h0000_1234, rd);
    wb_write(REG_RECT_Y, 32'h0000_0a05);
    wb_read(REG_RECT_Y, rd);
    check_value("rect y", 32'h0000_0a05, rd);
    wb_write(REG_COLOR, 32'h5a5a_c3e1);
    wb_read(REG_COLOR, rd);
    check_value("color", 32'h0000_c3e1, rd);
    auto_on = 1'b1;
    wb_write(REG_CTRL, ctrl_word(1'b0, 1'b0));
    wb_read(REG_CTRL, rd);
    check_value("ctrl auto", 32'h4, rd);
    auto_on = 1'b0;
    wb_write(REG_CTRL, ctrl_word(1'b0, 1'b0));
    for (int a = 5; a < 8; a++) begin
      wb_read(wb_adr_t'(a), rd);
      check_value($sformatf("unmapped %0d", a), 0, rd);
    end
    end_test();

    start_test("fill no swap");
    // At least three by two, so the second start lands while busy.
    xa = $urandom_range(disp_w - 3, 0);
    ya = $urandom_range(disp_h - 2, 0);
    run_fill(xa, $urandom_range(disp_w - 1, xa + 2), ya, $urandom_range(disp_h - 1, ya + 1),
             pixel_t'($urandom), 1'b1);
    wait_frames(2);
    end_test();

    start_test("manual swap");
    request_swap();
    end_test();

    start_test("auto swap fills");
    auto_on = 1'b1;
    for (int i = 0; i < auto_fills; i++) begin
      if (i == auto_fills - 2) begin
        run_fill(disp_w - 3, 200, disp_h - 2, 255, pixel_t'($urandom), 1'b0); // Off two edges.
      end else if (i == auto_fills - 1) begin
        run_fill(9, 3, 2, 6, pixel_t'($urandom), 1'b0); // Inverted in x.
      end else begin
        xa = $urandom_range(disp_w - 1, 0);
        ya = $urandom_range(disp_h - 1, 0);
        run_fill(xa, xa + $urandom_range(disp_w, 0), ya, ya + $urandom_range(disp_h, 0),
                 pixel_t'($urandom), 1'b0);
      end
      exp_front = 1 - exp_front;
      wait_swap();
    end
    end_test();

    start_test("double swap");
    auto_on    = 1'b0;
    orig_front = exp_front;
    request_swap();
    request_swap();
    wb_read(REG_STATUS, rd);
    check_value("front restored", orig_front, rd[STAT_FRONT]);
    end_test();

    $display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
             tests_run, tests_failed, checks, errors, DUT.u_regs.u_props.failures);
    if (errors == 0 && DUT.u_regs.u_props.failures == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
logic/fb_pkg.sv
logic/wb_regs_pkg.sv
logic/frame_ram.sv
logic/frame_buffer_pair.sv
logic/rect_fill_engine.sv
logic/fb_ctrl_regs.sv
logic/scan_reader.sv
logic/fb_subsystem_top.sv
tests/fb_subsystem_props.sv
tests/fb_subsystem_tb.sv

//--- Bender.yml
package:
  name: fb_subsystem

sources:
  - target: any(rtl, test)
    files:
      - logic/fb_pkg.sv
      - logic/wb_regs_pkg.sv
      - logic/frame_ram.sv
      - logic/frame_buffer_pair.sv
      - logic/rect_fill_engine.sv
      - logic/fb_ctrl_regs.sv
      - logic/scan_reader.sv
      - logic/fb_subsystem_top.sv
  - target: test
    files:
      - tests/fb_subsystem_props.sv
      - tests/fb_subsystem_tb.sv
